/* logic/spi_bus_pkg.sv */
package spi_bus_pkg;

  // One master's pin set, or the shared bus after the arbiter
  typedef struct packed {
    logic sck;
    logic cs_n;
    logic rs_dc;   // Low for command, high for data on the display
    logic mosi;
  } spi_pins_t;

  // Current bus owner as kept by the arbiter
  typedef enum logic [1:0] {
    OWNER_NONE,
    OWNER_DISPLAY,
    OWNER_SDCARD
  } spi_owner_e;

  // Levels on a parked bus, mode 0 clock idles low
  localparam spi_pins_t SPI_PINS_IDLE = '{
    sck:   1'b0,
    cs_n:  1'b1,
    rs_dc: 1'b0,
    mosi:  1'b0
  };

endpackage

/* logic/spi_xfer_pkg.sv */
package spi_xfer_pkg;

  localparam int MAX_BURST = 4;   // Bytes per burst at most

  typedef logic [7:0] spi_byte_t;

  // One burst as handed to a master with its start strobe
  typedef struct packed {
    logic [2:0]                  len;     // 1 to MAX_BURST
    logic                        rs_dc;   // Held for the whole burst
    spi_byte_t [MAX_BURST-1:0]   bytes;   // Byte 0 goes out first
  } spi_burst_t;

endpackage

/* logic/spi_burst_master.sv */
module spi_burst_master
  import spi_bus_pkg::*, spi_xfer_pkg::*;
#(
  parameter int CLK_DIV = 2
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  spi_burst_t burst,
  output logic       busy,
  output logic       req,
  input  logic       ack,
  output logic       done,
  output spi_pins_t  pins
);

  localparam int DIV_W  = $clog2(CLK_DIV + 1);
  localparam int BYTE_W = $clog2(MAX_BURST);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_ACK,
    ST_SHIFT,
    ST_FINISH
  } state_e;

  state_e            state;
  spi_burst_t        burst_q;
  logic [DIV_W-1:0]  div_cnt;
  logic              tick;
  logic [2:0]        bit_idx;
  logic [BYTE_W-1:0] byte_idx;
  logic              last_byte;

  assign tick      = (div_cnt == DIV_W'(CLK_DIV - 1));   // SCK half period over
  assign last_byte = (3'(byte_idx) == burst_q.len - 3'd1);

  // Burst payload, captured once per accepted start
  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && start)
      burst_q <= burst;
  end

  // Clock divider, restarted on grant so the first bit gets a full low phase
  always_ff @(posedge clk)
  begin
    if (rst || state == ST_IDLE || (state == ST_WAIT_ACK && ack))
      div_cnt <= '0;
    else if (tick)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= ST_IDLE;
      busy     <= 1'b0;
      req      <= 1'b0;
      done     <= 1'b0;
      pins     <= SPI_PINS_IDLE;
      bit_idx  <= '0;
      byte_idx <= '0;
    end
    else
    begin
      done <= 1'b0;

      case (state)
        ST_IDLE:
        begin
          if (start)
          begin
            state      <= ST_WAIT_ACK;
            busy       <= 1'b1;
            req        <= 1'b1;
            pins.rs_dc <= burst.rs_dc;
          end
        end

        ST_WAIT_ACK:
        begin
          if (ack)
          begin
            state     <= ST_SHIFT;
            pins.sck  <= 1'b0;
            pins.cs_n <= 1'b0;
            pins.mosi <= burst_q.bytes[0][7];   // MSB of the first byte
            bit_idx   <= 3'd7;
            byte_idx  <= '0;
          end
          else if (tick)
            pins.sck <= ~pins.sck;   // Free run so the arbiter can see edges
        end

        ST_SHIFT:
        begin
          if (tick)
          begin
            pins.sck <= ~pins.sck;
            if (pins.sck)   // Falling edge, move on to the next bit
            begin
              if (bit_idx == 3'd0)
              begin
                if (last_byte)
                  state <= ST_FINISH;
                else
                begin
                  byte_idx  <= byte_idx + 1'b1;
                  bit_idx   <= 3'd7;
                  pins.mosi <= burst_q.bytes[byte_idx + 1'b1][7];
                end
              end
              else
              begin
                bit_idx   <= bit_idx - 3'd1;
                pins.mosi <= burst_q.bytes[byte_idx][bit_idx - 3'd1];
              end
            end
          end
        end

        ST_FINISH:
        begin
          // One cycle after the last falling edge
          state     <= ST_IDLE;
          pins.cs_n <= 1'b1;
          pins.mosi <= 1'b0;
          done      <= 1'b1;
          busy      <= 1'b0;
          req       <= 1'b0;
        end

        default:
          state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* logic/spi_bus_arbiter.sv */
module spi_bus_arbiter
  import spi_bus_pkg::*;
#(
  parameter int SETTLE_EDGES = 3
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      disp_req,
  input  logic      disp_done,
  input  spi_pins_t disp_pins,
  output logic      disp_ack,
  input  logic      sd_req,
  input  logic      sd_done,
  input  spi_pins_t sd_pins,
  output logic      sd_ack,
  output spi_pins_t bus,
  output logic      display_cs,
  output logic      sdcard_cs
);

  localparam int CNT_W = $clog2(SETTLE_EDGES + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUESTED,
    ST_GRANTED
  } state_e;

  state_e           state;
  spi_owner_e       owner;
  spi_owner_e       next_owner;
  logic             arb_bit;   // Display wins a tie when set
  logic             owner_change;
  logic             owner_done;
  logic             sck_d;
  logic             sck_fall;
  logic [1:0]       blank;
  logic [CNT_W-1:0] settle_cnt;
  logic             settled;

  // Choice made in idle
  always_comb
  begin
    next_owner = owner;
    if (disp_req && sd_req)
      next_owner = arb_bit ? OWNER_DISPLAY : OWNER_SDCARD;
    else if (disp_req)
      next_owner = OWNER_DISPLAY;
    else if (sd_req)
      next_owner = OWNER_SDCARD;
  end

  assign owner_change = (state == ST_IDLE) && (disp_req || sd_req) && (next_owner != owner);

  assign owner_done = (owner == OWNER_DISPLAY) ? disp_done :
                      (owner == OWNER_SDCARD)  ? sd_done   : 1'b1;

  assign settled  = (settle_cnt >= CNT_W'(SETTLE_EDGES));
  assign sck_fall = sck_d && !bus.sck && !blank[0];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= ST_IDLE;
      owner    <= OWNER_SDCARD;   // SD card counts as last granted
      arb_bit  <= 1'b1;
      disp_ack <= 1'b0;
      sd_ack   <= 1'b0;
    end
    else
    begin
      disp_ack <= 1'b0;
      sd_ack   <= 1'b0;

      case (state)
        ST_IDLE:
        begin
          if (disp_req || sd_req)
          begin
            owner <= next_owner;
            state <= ST_REQUESTED;
          end
        end

        ST_REQUESTED:
        begin
          if (settled)
          begin
            state    <= ST_GRANTED;
            disp_ack <= (owner == OWNER_DISPLAY);
            sd_ack   <= (owner == OWNER_SDCARD);
            arb_bit  <= (owner == OWNER_SDCARD);   // Points away from the new owner
          end
        end

        ST_GRANTED:
        begin
          if (owner_done)
            state <= ST_IDLE;
        end

        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Settle count on the routed SCK
  // The bus lags the owner by a register, so edges are ignored for two cycles
  // after a switch to keep the old owner's clock out of the count
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sck_d      <= 1'b0;
      blank      <= 2'b00;
      settle_cnt <= '0;
    end
    else
    begin
      sck_d <= bus.sck;
      if (owner_change)
      begin
        blank      <= 2'b11;
        settle_cnt <= '0;
      end
      else
      begin
        blank <= {1'b0, blank[1]};
        if (sck_fall && !settled)
          settle_cnt <= settle_cnt + 1'b1;
      end
    end
  end

  // Registered pin multiplexer
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bus        <= SPI_PINS_IDLE;
      display_cs <= 1'b1;
      sdcard_cs  <= 1'b1;
    end
    else
    begin
      case (owner)
        OWNER_DISPLAY:
        begin
          bus        <= disp_pins;
          display_cs <= disp_pins.cs_n;
          sdcard_cs  <= 1'b1;
        end
        OWNER_SDCARD:
        begin
          bus        <= sd_pins;
          display_cs <= 1'b1;
          sdcard_cs  <= sd_pins.cs_n;
        end
        default:
        begin
          bus        <= SPI_PINS_IDLE;
          display_cs <= 1'b1;
          sdcard_cs  <= 1'b1;
        end
      endcase
    end
  end

endmodule

/* logic/spi_share_top.sv */
module spi_share_top
  import spi_bus_pkg::*, spi_xfer_pkg::*;
#(
  parameter int DISP_CLK_DIV = 2,
  parameter int SD_CLK_DIV   = 4,
  parameter int SETTLE_EDGES = 3
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       disp_start,
  input  spi_burst_t disp_burst,
  output logic       disp_busy,
  input  logic       sd_start,
  input  spi_burst_t sd_burst,
  output logic       sd_busy,
  output logic       sck,
  output logic       mosi,
  output logic       rs_dc,
  output logic       display_cs,
  output logic       sdcard_cs
);

  logic      disp_req;
  logic      disp_ack;
  logic      disp_done;
  spi_pins_t disp_pins;

  logic      sd_req;
  logic      sd_ack;
  logic      sd_done;
  spi_pins_t sd_pins;

  spi_pins_t bus;   // Chip selects leave through the per-device outputs

  spi_burst_master #(
    .CLK_DIV (DISP_CLK_DIV)
  ) u_disp_master (
    .clk   (clk),
    .rst   (rst),
    .start (disp_start),
    .burst (disp_burst),
    .busy  (disp_busy),
    .req   (disp_req),
    .ack   (disp_ack),
    .done  (disp_done),
    .pins  (disp_pins)
  );

  spi_burst_master #(
    .CLK_DIV (SD_CLK_DIV)
  ) u_sd_master (
    .clk   (clk),
    .rst   (rst),
    .start (sd_start),
    .burst (sd_burst),
    .busy  (sd_busy),
    .req   (sd_req),
    .ack   (sd_ack),
    .done  (sd_done),
    .pins  (sd_pins)
  );

  spi_bus_arbiter #(
    .SETTLE_EDGES (SETTLE_EDGES)
  ) u_arbiter (
    .clk        (clk),
    .rst        (rst),
    .disp_req   (disp_req),
    .disp_done  (disp_done),
    .disp_pins  (disp_pins),
    .disp_ack   (disp_ack),
    .sd_req     (sd_req),
    .sd_done    (sd_done),
    .sd_pins    (sd_pins),
    .sd_ack     (sd_ack),
    .bus        (bus),
    .display_cs (display_cs),
    .sdcard_cs  (sdcard_cs)
  );

  assign sck   = bus.sck;
  assign mosi  = bus.mosi;
  assign rs_dc = bus.rs_dc;

endmodule

/* bench/spi_share_checker.sv */
module spi_share_checker (
  input logic clk,
  input logic rst,
  input logic sck,
  input logic mosi,
  input logic rs_dc,
  input logic display_cs,
  input logic sdcard_cs
);

  int         mismatch_count = 0;
  int         fault_count = 0;
  logic [8:0] exp_q [1:0][$];   // {rs_dc, byte}, index 0 display, 1 SD card
  logic       owner_q [$];      // Expected order of chip select falls
  logic       sck_d;
  logic       disp_cs_d;
  logic       sd_cs_d;
  logic [7:0] shift;
  int         bit_cnt;

  function automatic string dev_name(input logic d);
    return d ? "sdcard" : "display";
  endfunction

  function void expect_byte(input logic d, input logic rs, input logic [7:0] data);
    exp_q[d].push_back({rs, data});
  endfunction

  function void expect_owner(input logic d);
    owner_q.push_back(d);
  endfunction

  function void check_owner(input logic d);
    logic want;
    if (owner_q.size() == 0)
    begin
      $display("Unexpected chip select fall on %s at %0t", dev_name(d), $time);
      fault_count++;
      return;
    end
    want = owner_q.pop_front();
    if (want != d)
    begin
      $display("MISMATCH at %0t: owner expected %s, got %s", $time, dev_name(want), dev_name(d));
      mismatch_count++;
    end
  endfunction

  function void take_bit(input logic d);
    logic [8:0] want;
    if (exp_q[d].size() == 0)
    begin
      $display("Unexpected bit on the %s bus at %0t", dev_name(d), $time);
      fault_count++;
      return;
    end
    want  = exp_q[d][0];
    shift = {shift[6:0], mosi};   // MSB arrives first
    bit_cnt++;
    if (rs_dc !== want[8])
    begin
      $display("MISMATCH at %0t: rs_dc expected %b, got %b", $time, want[8], rs_dc);
      mismatch_count++;
    end
    if (bit_cnt == 8)
    begin
      bit_cnt = 0;
      void'(exp_q[d].pop_front());
      if (shift !== want[7:0])
      begin
        $display("MISMATCH at %0t: mosi expected %02h, got %02h", $time, want[7:0], shift);
        mismatch_count++;
      end
    end
  endfunction

  function void final_check();
    int d;
    for (d = 0; d < 2; d++)
      if (exp_q[d].size() != 0)
      begin
        $display("%0d %s bytes were never sent", exp_q[d].size(), dev_name(d[0]));
        fault_count++;
      end
    if (owner_q.size() != 0)
    begin
      $display("%0d expected chip select falls never happened", owner_q.size());
      fault_count++;
    end
  endfunction

  // DUT outputs are registered, so values seen here are the settled ones
  always @(posedge clk)
  begin
    if (rst)
    begin
      sck_d     = 1'b0;
      disp_cs_d = 1'b1;
      sd_cs_d   = 1'b1;
      bit_cnt   = 0;
    end
    else
    begin
      if (disp_cs_d && !display_cs)
        check_owner(1'b0);
      if (sd_cs_d && !sdcard_cs)
        check_owner(1'b1);
      if (!sck_d && sck)
      begin
        if (!display_cs)
          take_bit(1'b0);
        else if (!sdcard_cs)
          take_bit(1'b1);
      end
      if ((!disp_cs_d && display_cs) || (!sd_cs_d && sdcard_cs))
      begin
        if (bit_cnt != 0)
        begin
          $display("Chip select rose in the middle of a byte at %0t", $time);
          fault_count++;
        end
        bit_cnt = 0;
      end
      sck_d     = sck;
      disp_cs_d = display_cs;
      sd_cs_d   = sdcard_cs;
    end
  end

endmodule

/* bench/spi_share_props.sv */
module spi_share_props
  import spi_bus_pkg::*;
#(
  parameter int SETTLE_EDGES = 3
) (
  input logic       clk,
  input logic       rst,
  input logic       disp_ack,
  input logic       sd_ack,
  input logic       display_cs,
  input logic       sdcard_cs,
  input spi_pins_t  bus,
  input spi_owner_e owner
);

  spi_owner_e owner_d;
  logic       sck_d;
  logic       pending;   // Owner switched and the new owner's cs is still high
  int         fall_cnt;
  int         fail_count = 0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      owner_d  <= OWNER_SDCARD;
      sck_d    <= 1'b0;
      pending  <= 1'b0;
      fall_cnt <= 0;
    end
    else
    begin
      owner_d <= owner;
      sck_d   <= bus.sck;
      if (owner != owner_d)
      begin
        pending  <= 1'b1;
        fall_cnt <= 0;
      end
      else if (!display_cs || !sdcard_cs)
        pending <= 1'b0;
      else if (sck_d && !bus.sck)
        fall_cnt <= fall_cnt + 1;
    end
  end

  cs_exclusive: assert property (@(posedge clk) disable iff (rst) display_cs || sdcard_cs)
    else
    begin
      $error("Both chip selects are low");
      fail_count++;
    end

  settle_before_cs: assert property (@(posedge clk) disable iff (rst)
    (pending && (!display_cs || !sdcard_cs)) |-> fall_cnt >= SETTLE_EDGES)
    else
    begin
      $error("Chip select fell before the bus clock settled");
      fail_count++;
    end

  disp_ack_pulse: assert property (@(posedge clk) disable iff (rst) disp_ack |=> !disp_ack)
    else
    begin
      $error("Display ack longer than one cycle");
      fail_count++;
    end

  sd_ack_pulse: assert property (@(posedge clk) disable iff (rst) sd_ack |=> !sd_ack)
    else
    begin
      $error("SD card ack longer than one cycle");
      fail_count++;
    end

  ack_exclusive: assert property (@(posedge clk) disable iff (rst) !(disp_ack && sd_ack))
    else
    begin
      $error("Ack given to both masters");
      fail_count++;
    end

endmodule

bind spi_bus_arbiter spi_share_props #(
  .SETTLE_EDGES (SETTLE_EDGES)
) u_props (
  .clk        (clk),
  .rst        (rst),
  .disp_ack   (disp_ack),
  .sd_ack     (sd_ack),
  .display_cs (display_cs),
  .sdcard_cs  (sdcard_cs),
  .bus        (bus),
  .owner      (owner)
);

/* bench/spi_share_tb.sv */
module spi_share_tb
  import spi_xfer_pkg::*;
();

  localparam int DISP_CLK_DIV = 2;
  localparam int SD_CLK_DIV   = 4;
  localparam int SETTLE_EDGES = 3;
  localparam int MAX_PATTERNS = 32;
  localparam int IDLE_TIMEOUT = 4000;   // Cycles per group of bursts

  logic        clk;
  logic        rst;
  logic        disp_start;
  logic        sd_start;
  spi_burst_t  disp_burst;
  spi_burst_t  sd_burst;
  logic        disp_busy;
  logic        sd_busy;
  logic        sck;
  logic        mosi;
  logic        rs_dc;
  logic        display_cs;
  logic        sdcard_cs;

  logic [7:0]  pat_tgt [MAX_PATTERNS];
  logic        pat_tie [MAX_PATTERNS];
  spi_burst_t  pat_burst [MAX_PATTERNS];
  int          n_pat;
  int          tb_errors;
  logic        last_granted;   // Set when the SD card had the bus last
  logic [31:0] rng_state;

  spi_share_top #(
    .DISP_CLK_DIV (DISP_CLK_DIV),
    .SD_CLK_DIV   (SD_CLK_DIV),
    .SETTLE_EDGES (SETTLE_EDGES)
  ) i_spi_share_top (
    .clk        (clk),
    .rst        (rst),
    .disp_start (disp_start),
    .disp_burst (disp_burst),
    .disp_busy  (disp_busy),
    .sd_start   (sd_start),
    .sd_burst   (sd_burst),
    .sd_busy    (sd_busy),
    .sck        (sck),
    .mosi       (mosi),
    .rs_dc      (rs_dc),
    .display_cs (display_cs),
    .sdcard_cs  (sdcard_cs)
  );

  spi_share_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .sck        (sck),
    .mosi       (mosi),
    .rs_dc      (rs_dc),
    .display_cs (display_cs),
    .sdcard_cs  (sdcard_cs)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  task automatic read_patterns();
    int         fd;
    int         code;
    string      line;
    logic [7:0] tgt;
    int         tie;
    int         len;
    int         rs;
    logic [7:0] b [4];
    fd = $fopen("bench/spi_share_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the pattern file");
      tb_errors++;
      return;
    end
    while (!$feof(fd) && n_pat < MAX_PATTERNS)
    begin
      code = $fgets(line, fd);
      if (code > 1 && line[0] != "#")
      begin
        code = $sscanf(line, "%c %d %d %d %h %h %h %h", tgt, tie, len, rs,
                       b[0], b[1], b[2], b[3]);
        if (code == 8)
        begin
          pat_tgt[n_pat]         = tgt;
          pat_tie[n_pat]         = (tie != 0);
          pat_burst[n_pat].len   = 3'(len);
          pat_burst[n_pat].rs_dc = rs[0];
          pat_burst[n_pat].bytes = {b[3], b[2], b[1], b[0]};
          n_pat++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while ((disp_busy || sd_busy) && cycles < IDLE_TIMEOUT)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (disp_busy || sd_busy)
    begin
      $display("Timeout at %0t: bursts did not finish within %0d cycles", $time, IDLE_TIMEOUT);
      tb_errors++;
    end
  endtask

  task automatic push_expected(input logic dev, input spi_burst_t b);
    int k;
    for (k = 0; k < b.len; k++)
      u_checker.expect_byte(dev, b.rs_dc, b.bytes[k]);
  endtask

  // One line alone, or two tie lines started in the same cycle
  task automatic send_group(input int a, input int b);
    logic       go_disp;
    logic       go_sd;
    logic       winner;
    spi_burst_t db;
    spi_burst_t sb;
    spi_burst_t junk;
    int         idx [2];
    int         k;
    if (b >= 0 && pat_tgt[a] == pat_tgt[b])
    begin
      $display("Tie lines %0d and %0d name the same device", a, b);
      tb_errors++;
      return;
    end
    go_disp = 1'b0;
    go_sd   = 1'b0;
    db      = '0;
    sb      = '0;
    idx[0]  = a;
    idx[1]  = b;
    for (k = 0; k < ((b < 0) ? 1 : 2); k++)
    begin
      if (pat_tgt[idx[k]] == "S")
      begin
        go_sd = 1'b1;
        sb    = pat_burst[idx[k]];
      end
      else
      begin
        go_disp = 1'b1;
        db      = pat_burst[idx[k]];
      end
      push_expected(pat_tgt[idx[k]] == "S", pat_burst[idx[k]]);
    end
    if (go_disp && go_sd)
    begin
      winner = !last_granted;   // Tie goes to the master not granted last
      u_checker.expect_owner(winner);
      u_checker.expect_owner(!winner);
      last_granted = !winner;
    end
    else
    begin
      u_checker.expect_owner(go_sd);
      last_granted = go_sd;
    end
    junk = {3'd4, 1'b1, next_random()};
    @(posedge clk);
    #1;
    disp_start = go_disp;
    sd_start   = go_sd;
    disp_burst = db;
    sd_burst   = sb;
    @(posedge clk);
    #1;
    disp_start = 1'b0;
    sd_start   = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    disp_start = go_disp;   // Comes while busy is high and must be dropped
    sd_start   = go_sd;
    disp_burst = junk;
    sd_burst   = junk;
    @(posedge clk);
    #1;
    disp_start = 1'b0;
    sd_start   = 1'b0;
    wait_idle();
  endtask

  initial
  begin
    int i;
    int gap;
    int total;
    rst          = 1'b1;
    disp_start   = 1'b0;
    sd_start     = 1'b0;
    disp_burst   = '0;
    sd_burst     = '0;
    n_pat        = 0;
    tb_errors    = 0;
    last_granted = 1'b1;   // Arbiter starts with the SD card as owner
    rng_state    = 32'd51203;
    read_patterns();
    if (n_pat == 0)
    begin
      $display("No bursts were read from the pattern file");
      tb_errors++;
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    i   = 0;
    while (i < n_pat)
    begin
      if (pat_tie[i] && i + 1 < n_pat)
      begin
        send_group(i, i + 1);
        i += 2;
      end
      else
      begin
        send_group(i, -1);
        i++;
      end
      gap = next_random() % 8;
      repeat (gap) @(posedge clk);
    end
    repeat (20) @(posedge clk);
    u_checker.final_check();
    total = u_checker.mismatch_count + u_checker.fault_count + tb_errors
            + i_spi_share_top.u_arbiter.u_props.fail_count;
    $display("Errors: %0d mismatches, %0d checker, %0d assertions, %0d testbench",
             u_checker.mismatch_count, u_checker.fault_count,
             i_spi_share_top.u_arbiter.u_props.fail_count, tb_errors);
    if (total == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* spi_share.f */
logic/spi_bus_pkg.sv
logic/spi_xfer_pkg.sv
logic/spi_burst_master.sv
logic/spi_bus_arbiter.sv
logic/spi_share_top.sv
bench/spi_share_checker.sv
bench/spi_share_props.sv
bench/spi_share_tb.sv

/* Bender.yml */
package:
  name: spi_share

sources:
  - files:
      - logic/spi_bus_pkg.sv
      - logic/spi_xfer_pkg.sv
      - logic/spi_burst_master.sv
      - logic/spi_bus_arbiter.sv
      - logic/spi_share_top.sv
  - target: simulation
    files:
      - bench/spi_share_checker.sv
      - bench/spi_share_props.sv
      - bench/spi_share_tb.sv

/* bench/spi_share_patterns.txt */
# target(D or S) tie(1 = starts with the next line) len rs_dc byte0 byte1 byte2 byte3
# Bytes are hex, bytes past len are not sent
D 0 1 0 2a 00 00 00
D 0 4 1 a5 5a ff 01
S 0 2 0 40 95 00 00
S 0 4 1 de ad be ef
D 1 3 1 11 22 33 00
S 0 2 0 c3 3c 00 00
S 1 4 0 80 01 7e e7
D 0 1 1 f0 00 00 00
D 0 2 0 2c 81 00 00
D 1 2 1 55 aa 00 00
S 0 1 1 0f 00 00 00
S 0 3 1 12 34 56 00
